/* filelist.f */
source/noc_pkg.sv
source/flit_fifo.sv
source/xy_route.sv
source/switch_alloc.sv
source/crossbar.sv
source/router_node.sv
sim/router_chk.sv
sim/router_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the router testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module router_tb -f filelist.f -o router_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/router_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q -F "** FAIL **" "$log"; then
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
exit 0

/* sim/router_tb.sv */
`timescale 1ns/1ps

module router_tb;

   localparam int np         = noc_pkg::num_ports;
   localparam int fifo_depth = 4;
   localparam int clk_period = 10;
   localparam logic [noc_pkg::x_width-1:0] node_x = 2'd1;
   localparam logic [noc_pkg::y_width-1:0] node_y = 2'd2;

   // directed row, input port, flit, expected output port
   typedef struct packed {
      logic [2:0]     in_port;
      noc_pkg::flit_t flit;
      logic [2:0]     out_port;
   } row_t;

   // node sits at x 1, y 2
   localparam row_t dir_tbl [8] = '{
      {3'd0, 8'ha3, 3'd1},   // to 3,0 east
      {3'd4, 8'h5c, 3'd2},   // to 0,3 west
      {3'd2, 8'h3d, 3'd3},   // to 1,3 south
      {3'd1, 8'hc1, 3'd4},   // to 1,0 north
      {3'd3, 8'h79, 3'd0},   // to 1,2 local
      {3'd0, 8'h0a, 3'd1},   // to 2,2 east
      {3'd1, 8'hf5, 3'd4},   // to 1,1 north
      {3'd3, 8'h98, 3'd2}    // to 0,2 west
   };

   logic                clk;
   logic                rst_n;
   noc_pkg::link_t      in_link  [np];
   noc_pkg::port_mask_t in_full;
   noc_pkg::link_t      out_link [np];

   // offers staged for the next drive, and which ones went in
   noc_pkg::link_t      stim [np];
   noc_pkg::port_mask_t taken;
   noc_pkg::port_mask_t full_seen;

   // expected flits, one queue per output and source pair
   noc_pkg::flit_t exp_q [np*np][$];
   int seed;

   // other deliveries per output and source pair since that source was last served
   int   passed [np*np];
   logic fair_on;

   router_node #(
      .node_x     (node_x),
      .node_y     (node_y),
      .fifo_depth (fifo_depth)
   ) dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_link  (in_link),
      .in_full  (in_full),
      .out_link (out_link)
   );

   bind router_node router_chk u_chk (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_link  (in_link),
      .in_full  (in_full),
      .grant    (grant),
      .out_link (out_link)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // reference rule and checks
   //////////////////////////////////////////////////////////////////////

   // x first, then y, else local
   function automatic int route_ref(input noc_pkg::flit_t f);
      int dx;
      int dy;
      dx = int'(f.dest_x) - int'(node_x);
      dy = int'(f.dest_y) - int'(node_y);
      if (dx > 0) return noc_pkg::port_east;
      if (dx < 0) return noc_pkg::port_west;
      if (dy > 0) return noc_pkg::port_south;
      if (dy < 0) return noc_pkg::port_north;
      return noc_pkg::port_local;
   endfunction

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_flit(input string name, input noc_pkg::flit_t got,
                             input noc_pkg::flit_t exp);
      if (got !== exp) begin
         stop_with_error($sformatf("mismatch at %0t: %s got %h expected %h",
                                   $time, name, got, exp));
      end
   endtask

   task automatic check_port(input string name, input noc_pkg::port_mask_t got,
                             input noc_pkg::port_mask_t exp);
      if (got !== exp) begin
         stop_with_error($sformatf("mismatch at %0t: %s got %b expected %b",
                                   $time, name, got, exp));
      end
   endtask

   function automatic noc_pkg::port_mask_t valid_mask();
      noc_pkg::port_mask_t m;
      for (int o = 0; o < np; o++) m[o] = out_link[o].valid;
      return m;
   endfunction

   function automatic int count_pending(input int o);
      int n;
      n = 0;
      for (int s = 0; s < np; s++) n += exp_q[o*np+s].size();
      return n;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // scoreboard
   //////////////////////////////////////////////////////////////////////

   // a waiting source sees at most np-1 other grants before its own
   task automatic note_grant(input int o, input int s);
      passed[o*np+s] = 0;
      for (int q = 0; q < np; q++) begin
         if (q != s && exp_q[o*np+q].size() > 0) begin
            passed[o*np+q]++;
            if (passed[o*np+q] > np - 1) begin
               stop_with_error($sformatf("input %0d waited more than %0d grants for output %0d",
                                         q, np - 1, o));
            end
         end
      end
   endtask

   // match against the oldest flit of each source for this output
   task automatic take_delivery(input int o, input noc_pkg::flit_t f);
      int hit;
      int oldest;
      hit = -1;
      oldest = -1;
      for (int s = 0; s < np; s++) begin
         if (exp_q[o*np+s].size() > 0) begin
            if (oldest < 0) oldest = s;
            if (hit < 0 && exp_q[o*np+s][0] == f) hit = s;
         end
      end
      if (hit >= 0) begin
         void'(exp_q[o*np+hit].pop_front());
         if (fair_on) note_grant(o, hit);
      end else if (oldest >= 0) begin
         check_flit($sformatf("out_link[%0d].flit", o), f, exp_q[o*np+oldest][0]);
      end else begin
         stop_with_error($sformatf("output %0d delivered flit %h that nobody sent", o, f));
      end
   endtask

   // outputs are stable mid cycle
   always @(negedge clk) begin
      if (rst_n) begin
         for (int o = 0; o < np; o++) begin
            if (out_link[o].valid) take_delivery(o, out_link[o].flit);
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic clear_stim();
      for (int p = 0; p < np; p++) stim[p] = '0;
   endtask

   // one drive cycle, a full port gets no strobe
   task automatic apply_stim();
      @(posedge clk);
      #1;
      full_seen = full_seen | in_full;
      for (int p = 0; p < np; p++) begin
         taken[p]         = stim[p].valid && !in_full[p];
         in_link[p].valid = taken[p];
         in_link[p].flit  = stim[p].flit;
         if (taken[p]) exp_q[route_ref(stim[p].flit)*np + p].push_back(stim[p].flit);
      end
   endtask

   // each source sends rounds flits to one destination, payload tags the source
   task automatic send_rounds(input noc_pkg::port_mask_t srcs, input int rounds,
                              input logic [1:0] dx, input logic [1:0] dy);
      int sent [np];
      int guard;
      logic busy;
      guard = 0;
      busy  = 1'b1;
      for (int p = 0; p < np; p++) sent[p] = srcs[p] ? 0 : rounds;
      while (busy) begin
         if (guard > 8 * rounds) stop_with_error("inputs stayed full, flits could not be sent");
         clear_stim();
         for (int p = 0; p < np; p++) begin
            if (sent[p] < rounds) begin
               stim[p].valid = 1'b1;
               stim[p].flit  = {1'(sent[p]), 3'(p), dy, dx};
            end
         end
         apply_stim();
         busy = 1'b0;
         for (int p = 0; p < np; p++) begin
            if (taken[p]) sent[p]++;
            if (sent[p] < rounds) busy = 1'b1;
         end
         guard++;
      end
      clear_stim();
      apply_stim();
   endtask

   task automatic wait_drain(input int limit);
      int cycles;
      int late;
      cycles = 0;
      late   = -1;
      for (int o = 0; o < np; o++) if (late < 0 && count_pending(o) != 0) late = o;
      while (late >= 0) begin
         if (cycles >= limit) begin
            stop_with_error($sformatf("timeout: output %0d never delivered %0d expected flits",
                                      late, count_pending(late)));
         end
         @(posedge clk);
         cycles++;
         late = -1;
         for (int o = 0; o < np; o++) if (late < 0 && count_pending(o) != 0) late = o;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      noc_pkg::port_mask_t exp_mask;
      logic [31:0] rnd;
      int left;
      int dx_r;
      int dy_r;
      seed      = 32'h62c9_325e;
      rst_n     = 1'b0;
      full_seen = '0;
      taken     = '0;
      fair_on   = 1'b0;
      for (int i = 0; i < np*np; i++) passed[i] = 0;
      clear_stim();
      for (int p = 0; p < np; p++) in_link[p] = '0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // idle after reset
      check_port("out_link valid", valid_mask(), '0);
      check_port("in_full", in_full, '0);

      // directed rows, uncontended latency of one cycle
      for (int r = 0; r < 8; r++) begin
         clear_stim();
         stim[dir_tbl[r].in_port].valid = 1'b1;
         stim[dir_tbl[r].in_port].flit  = dir_tbl[r].flit;
         apply_stim();
         clear_stim();
         apply_stim();
         @(posedge clk);
         @(negedge clk);
         exp_mask = '0;
         exp_mask[dir_tbl[r].out_port] = 1'b1;
         check_port("out_link valid", valid_mask(), exp_mask);
         check_flit($sformatf("out_link[%0d].flit", dir_tbl[r].out_port),
                    out_link[dir_tbl[r].out_port].flit, dir_tbl[r].flit);
         wait_drain(4);
      end

      // in order from west to east
      send_rounds(5'b00100, 4, 2'd3, 2'd0);
      wait_drain(8);

      // four neighbours to local, one round then a burst
      fair_on = 1'b1;
      send_rounds(5'b11110, 1, node_x, node_y);
      wait_drain(np);
      send_rounds(5'b11110, 4, node_x, node_y);
      wait_drain(4 * np);

      // all inputs fill up behind the local output
      full_seen = '0;
      send_rounds(5'b11111, fifo_depth, node_x, node_y);
      if (full_seen == '0) stop_with_error("in_full never rose while local was contended");
      wait_drain(fifo_depth * np + np);
      @(negedge clk);
      check_port("in_full", in_full, '0);

      // random traffic on every input, head of line blocking allowed
      fair_on = 1'b0;
      for (int c = 0; c < 200; c++) begin
         clear_stim();
         for (int p = 0; p < np; p++) begin
            rnd = $random(seed);
            if (rnd[0]) begin
               // destination anywhere in the mesh
               dx_r = int'(rnd[15:8]) % noc_pkg::x_node_num;
               dy_r = int'(rnd[23:16]) % noc_pkg::y_node_num;
               stim[p].valid = 1'b1;
               stim[p].flit  = {rnd[1], 3'(p), dy_r[noc_pkg::y_width-1:0],
                                dx_r[noc_pkg::x_width-1:0]};
            end
         end
         apply_stim();
      end
      clear_stim();
      apply_stim();
      wait_drain(200);

      left = 0;
      for (int o = 0; o < np; o++) left += count_pending(o);
      if (left != 0) begin
         stop_with_error($sformatf("%0d expected flits were never delivered", left));
      end else begin
         $display("** PASS **");
         $finish;
      end
   end

endmodule

/* sim/router_chk.sv */
`timescale 1ns/1ps

module router_chk (
   input logic                clk,
   input logic                rst_n,
   input noc_pkg::link_t      in_link  [noc_pkg::num_ports],
   input noc_pkg::port_mask_t in_full,
   input noc_pkg::port_mask_t grant    [noc_pkg::num_ports],
   input noc_pkg::link_t      out_link [noc_pkg::num_ports]
);

   // input strobes gathered into one mask
   noc_pkg::port_mask_t push_mask;

   always_comb begin
      for (int p = 0; p < noc_pkg::num_ports; p++) begin
         push_mask[p] = in_link[p].valid;
      end
   end

   // sender holds back while the level is high
   a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n)
      (push_mask & in_full) == '0)
      else $error("push into a full input buffer, ports %b", push_mask & in_full);

   for (genvar o = 0; o < noc_pkg::num_ports; o++) begin : g_out
      // at most one winner per output
      a_grant_onehot : assert property (@(posedge clk) disable iff (!rst_n)
         $onehot0(grant[o]))
         else $error("output %0d granted to several inputs %b", o, grant[o]);

      // every strobe traces back to a grant one cycle earlier
      a_valid_from_grant : assert property (@(posedge clk) disable iff (!rst_n)
         out_link[o].valid |-> $past(|grant[o]))
         else $error("output %0d strobed without a grant", o);
   end

endmodule

/* source/router_node.sv */
`timescale 1ns/1ps

module router_node #(
   parameter logic [noc_pkg::x_width-1:0] node_x     = '0,
   parameter logic [noc_pkg::y_width-1:0] node_y     = '0,
   parameter int                          fifo_depth = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  noc_pkg::link_t      in_link  [noc_pkg::num_ports],
   output noc_pkg::port_mask_t in_full,
   output noc_pkg::link_t      out_link [noc_pkg::num_ports]
);

   // head of each input buffer
   logic                head_valid [noc_pkg::num_ports];
   noc_pkg::flit_t      head_flit  [noc_pkg::num_ports];

   // route requests by input, grants by output
   noc_pkg::port_mask_t request [noc_pkg::num_ports];
   noc_pkg::port_mask_t grant   [noc_pkg::num_ports];
   noc_pkg::port_mask_t pop;

   //////////////////////////////////////////////////////////////////////
   // input ports
   //////////////////////////////////////////////////////////////////////

   for (genvar p = 0; p < noc_pkg::num_ports; p++) begin : g_port
      // buffer, full level goes back to the sender
      flit_fifo #(
         .depth (fifo_depth)
      ) u_fifo (
         .clk        (clk),
         .rst_n      (rst_n),
         .push       (in_link[p].valid),
         .push_flit  (in_link[p].flit),
         .pop        (pop[p]),
         .head_valid (head_valid[p]),
         .head_flit  (head_flit[p]),
         .full       (in_full[p])
      );

      // xy decision on the head flit
      xy_route #(
         .node_x (node_x),
         .node_y (node_y)
      ) u_route (
         .head_valid (head_valid[p]),
         .head_flit  (head_flit[p]),
         .request    (request[p])
      );
   end

   //////////////////////////////////////////////////////////////////////
   // allocation and switch
   //////////////////////////////////////////////////////////////////////

   switch_alloc u_alloc (
      .clk     (clk),
      .rst_n   (rst_n),
      .request (request),
      .grant   (grant),
      .pop     (pop)
   );

   // one register stage to the outputs
   crossbar u_xbar (
      .clk       (clk),
      .rst_n     (rst_n),
      .grant     (grant),
      .head_flit (head_flit),
      .out_link  (out_link)
   );

endmodule

/* source/crossbar.sv */
`timescale 1ns/1ps

module crossbar (
   input  logic                clk,
   input  logic                rst_n,
   input  noc_pkg::port_mask_t grant     [noc_pkg::num_ports],
   input  noc_pkg::flit_t      head_flit [noc_pkg::num_ports],
   output noc_pkg::link_t      out_link  [noc_pkg::num_ports]
);

   localparam int flit_w = $bits(noc_pkg::flit_t);

   // selected head flit per output
   noc_pkg::flit_t sel_flit [noc_pkg::num_ports];

   // output stage
   logic           valid_q [noc_pkg::num_ports];
   noc_pkg::flit_t flit_q  [noc_pkg::num_ports];

   // and-or mux, grant is one-hot or zero
   always_comb begin
      for (int o = 0; o < noc_pkg::num_ports; o++) begin
         sel_flit[o] = '0;
         for (int i = 0; i < noc_pkg::num_ports; i++) begin
            sel_flit[o] = sel_flit[o] | ({flit_w{grant[o][i]}} & head_flit[i]);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////
   // register stage
   ////////////////////////////////////////////////////////////////////

   // valid is a single cycle strobe
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int o = 0; o < noc_pkg::num_ports; o++) begin
            valid_q[o] <= 1'b0;
         end
      end else begin
         for (int o = 0; o < noc_pkg::num_ports; o++) begin
            valid_q[o] <= |grant[o];
         end
      end
   end

   // flit only loads on a grant
   always_ff @(posedge clk) begin
      for (int o = 0; o < noc_pkg::num_ports; o++) begin
         if (|grant[o]) begin
            flit_q[o] <= sel_flit[o];
         end
      end
   end

   always_comb begin
      for (int o = 0; o < noc_pkg::num_ports; o++) begin
         out_link[o].valid = valid_q[o];
         out_link[o].flit  = flit_q[o];
      end
   end

endmodule

/* source/switch_alloc.sv */
`timescale 1ns/1ps

module switch_alloc (
   input  logic                clk,
   input  logic                rst_n,
   input  noc_pkg::port_mask_t request [noc_pkg::num_ports],
   output noc_pkg::port_mask_t grant   [noc_pkg::num_ports],
   output noc_pkg::port_mask_t pop
);

   localparam int ptr_w = $clog2(noc_pkg::num_ports);

   // requests seen per output, indexed by input
   noc_pkg::port_mask_t req_by_out [noc_pkg::num_ports];

   // round robin start point per output
   logic [ptr_w-1:0] rr_ptr [noc_pkg::num_ports];

   // winning input per output this cycle
   logic [ptr_w-1:0] winner [noc_pkg::num_ports];
   logic             won    [noc_pkg::num_ports];

   ////////////////////////////////////////////////////////////////////
   // request transpose
   ////////////////////////////////////////////////////////////////////

   // each input raises at most one output bit
   always_comb begin
      for (int o = 0; o < noc_pkg::num_ports; o++) begin
         for (int i = 0; i < noc_pkg::num_ports; i++) begin
            req_by_out[o][i] = request[i][o];
         end
      end
   end

   ////////////////////////////////////////////////////////////////////
   // per output arbitration
   ////////////////////////////////////////////////////////////////////

   always_comb begin
      int idx;
      for (int o = 0; o < noc_pkg::num_ports; o++) begin
         grant[o]  = '0;
         winner[o] = '0;
         won[o]    = 1'b0;
         // scan upward from the pointer, wrap at num_ports
         for (int k = 0; k < noc_pkg::num_ports; k++) begin
            idx = (int'(rr_ptr[o]) + k) % noc_pkg::num_ports;
            if (!won[o] && req_by_out[o][idx]) begin
               won[o]         = 1'b1;
               winner[o]      = ptr_w'(idx);
               grant[o][idx]  = 1'b1;
            end
         end
      end
   end

   // pointer moves just past the winner
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int o = 0; o < noc_pkg::num_ports; o++) begin
            rr_ptr[o] <= ptr_w'(noc_pkg::port_local);
         end
      end else begin
         for (int o = 0; o < noc_pkg::num_ports; o++) begin
            if (won[o]) begin
               if (winner[o] == ptr_w'(noc_pkg::num_ports - 1)) begin
                  rr_ptr[o] <= '0;
               end else begin
                  rr_ptr[o] <= winner[o] + 1'b1;
               end
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////
   // fifo pops
   ////////////////////////////////////////////////////////////////////

   // one output per input, so the union of grants names every popped input
   always_comb begin
      pop = '0;
      for (int o = 0; o < noc_pkg::num_ports; o++) begin
         pop = pop | grant[o];
      end
   end

endmodule

/* source/xy_route.sv */
`timescale 1ns/1ps

module xy_route #(
   parameter logic [noc_pkg::x_width-1:0] node_x = '0,
   parameter logic [noc_pkg::y_width-1:0] node_y = '0
) (
   input  logic                head_valid,
   input  noc_pkg::flit_t      head_flit,
   output noc_pkg::port_mask_t request
);

   // one extra bit so the difference keeps its sign
   logic signed [noc_pkg::x_width:0] x_cur;
   logic signed [noc_pkg::x_width:0] x_dst;
   logic signed [noc_pkg::y_width:0] y_cur;
   logic signed [noc_pkg::y_width:0] y_dst;
   logic signed [noc_pkg::x_width:0] x_diff;
   logic signed [noc_pkg::y_width:0] y_diff;

   // coordinates are unsigned, zero extend before the subtraction
   assign x_cur  = $signed({1'b0, node_x});
   assign y_cur  = $signed({1'b0, node_y});
   assign x_dst  = $signed({1'b0, head_flit.dest_x});
   assign y_dst  = $signed({1'b0, head_flit.dest_y});
   assign x_diff = x_dst - x_cur;
   assign y_diff = y_dst - y_cur;

   ////////////////////////////////////////////////////////////////////
   // dimension ordered decision
   ////////////////////////////////////////////////////////////////////

   always_comb begin
      request = '0;
      if (head_valid) begin
         // x first
         if (x_diff > 0) begin
            request[noc_pkg::port_east] = 1'b1;
         end else if (x_diff < 0) begin
            request[noc_pkg::port_west] = 1'b1;
         // then y, south grows the row index
         end else if (y_diff > 0) begin
            request[noc_pkg::port_south] = 1'b1;
         end else if (y_diff < 0) begin
            request[noc_pkg::port_north] = 1'b1;
         end else begin
            // arrived at this node
            request[noc_pkg::port_local] = 1'b1;
         end
      end
   end

endmodule

/* source/flit_fifo.sv */
`timescale 1ns/1ps

module flit_fifo #(
   parameter int depth = 4
) (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           push,
   input  noc_pkg::flit_t push_flit,
   input  logic           pop,
   output logic           head_valid,
   output noc_pkg::flit_t head_flit,
   output logic           full
);

   // pointer and count widths, guarded for depth 1
   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   // flit storage
   noc_pkg::flit_t mem [depth];

   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic [cnt_w-1:0] count_next;

   logic do_push;
   logic do_pop;

   // a write into a full buffer is dropped
   assign do_push = push && !full;
   // pop only with something at the head
   assign do_pop  = pop && head_valid;

   always_comb begin
      count_next = count;
      if (do_push && !do_pop) begin
         count_next = count + 1'b1;
      end else if (do_pop && !do_push) begin
         count_next = count - 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // pointers, count and full level
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         full   <= 1'b0;
      end else begin
         // wrap by compare, depth need not be a power of two
         if (do_push) begin
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count_next;
         // registered level, high once every slot is taken
         full  <= (count_next == cnt_w'(depth));
      end
   end

   // payload array
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_flit;
      end
   end

   // head visible right after the write edge
   assign head_valid = (count != '0);
   assign head_flit  = mem[rd_ptr];

endmodule

/* source/noc_pkg.sv */
package noc_pkg;

   //////////////////////////////////////////////////////////////////////
   // mesh geometry
   //////////////////////////////////////////////////////////////////////

   // 4 by 4 mesh
   localparam int x_node_num = 4;
   localparam int y_node_num = 4;

   // coordinate field widths
   localparam int x_width = 2;
   localparam int y_width = 2;

   // local plus four neighbours
   localparam int num_ports = 5;

   // port order, same as the e1 to e5 enables of the route block
   localparam int port_local = 0;
   localparam int port_east  = 1;
   localparam int port_west  = 2;
   localparam int port_south = 3;
   localparam int port_north = 4;

   //////////////////////////////////////////////////////////////////////
   // flit and link types
   //////////////////////////////////////////////////////////////////////

   // one bit per port, zero means no request
   typedef logic [num_ports-1:0] port_mask_t;

   // single flit packet, destination in the low nibble
   typedef struct packed {
      logic [3:0]         payload;
      logic [y_width-1:0] dest_y;
      logic [x_width-1:0] dest_x;
   } flit_t;

   // one router port, valid strobe plus flit
   typedef struct packed {
      logic  valid;
      flit_t flit;
   } link_t;

endpackage
